//--- flist.f
hw/dcache_pkg.sv
hw/dcache_main_fsm.sv
hw/dcache_tagv_array.sv
hw/dcache_data_array.sv
hw/dcache_lru.sv
hw/dcache_writeback_fsm.sv
hw/dcache_top.sv
verif/dcache_clkgen.sv
verif/dcache_tb.sv

//--- hw/dcache_data_array.sv
`timescale 1ns/1ps

module dcache_data_array (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic [dcache_pkg::INDEX_W-1:0]      index,
    input  logic [31:0]                         mem_we,
    input  logic [dcache_pkg::LINE_BYTES*8-1:0] store_data,
    input  logic                                refill_sel,
    input  logic                                d_rvalid,
    input  logic                                d_rready,
    input  logic [31:0]                         d_rdata,
    input  logic [1:0]                          hit,
    input  logic                                way_sel,
    output logic [dcache_pkg::LINE_BYTES*8-1:0] hit_line,
    output logic [dcache_pkg::LINE_BYTES*8-1:0] victim_line
);
    import dcache_pkg::*;

    logic [LINE_BYTES*8-1:0]           data_mem [WAY_NUM][SET_NUM];
    logic [LINE_BYTES*8-1:0]           refill_buf;
    logic [LINE_BYTES*8-1:0]           write_src;
    logic [$clog2(WORDS_PER_LINE)-1:0] beat_cnt;

    // Refill beat position
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else if (d_rvalid && d_rready) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (d_rvalid && d_rready) begin
            refill_buf[beat_cnt*32 +: 32] <= d_rdata;
        end
    end

    assign write_src = refill_sel ? refill_buf : store_data;

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAY_NUM; w++) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (mem_we[w*LINE_BYTES+b]) begin
                    data_mem[w][index][b*8 +: 8] <= write_src[b*8 +: 8];
                end
            end
        end
    end

    assign hit_line    = hit[1] ? data_mem[1][index] : data_mem[0][index];
    assign victim_line = data_mem[way_sel][index];

endmodule

//--- hw/dcache_lru.sv
`timescale 1ns/1ps

module dcache_lru (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [dcache_pkg::INDEX_W-1:0] index,
    input  logic                           lru_update,
    input  logic [1:0]                     hit,
    input  logic                           miss_lru_update,
    input  logic                           miss_way,
    output logic                           way_sel
);
    import dcache_pkg::*;

    // Set bit names the next way to replace
    logic [SET_NUM-1:0] lru_bits;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_bits <= '0;
        end else if (miss_lru_update) begin
            lru_bits[index] <= ~miss_way;
        end else if (lru_update) begin
            lru_bits[index] <= (hit == 2'b01);
        end
    end

    assign way_sel = lru_bits[index];

endmodule

//--- hw/dcache_main_fsm.sv
`timescale 1ns/1ps

module dcache_main_fsm (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          req_fire,
    input  logic                          pipe_valid,
    input  logic                          pipe_we,
    input  dcache_pkg::mem_type_e         pipe_type,
    input  logic [dcache_pkg::ADDR_W-1:0] pipe_addr,
    input  logic [1:0]                    hit,
    input  logic                          way_sel,
    input  logic                          d_arready,
    input  logic                          d_rvalid,
    input  logic                          d_rlast,
    input  logic                          write_finish,
    output logic                          req_ready,
    output logic                          resp_valid,
    output logic [31:0]                   mem_we,
    output logic [1:0]                    tag_we,
    output logic                          lru_update,
    output logic                          miss_lru_update,
    output logic                          miss_way,
    output logic                          refill_sel,
    output logic                          d_arvalid,
    output logic [dcache_pkg::ADDR_W-1:0] d_araddr,
    output logic                          d_rready,
    output logic                          wb_start,
    output logic                          wb_clear
);
    import dcache_pkg::*;

    cache_state_e          state;
    cache_state_e          state_next;
    logic [LINE_BYTES-1:0] store_be;
    logic                  is_hit;

    assign is_hit = pipe_valid && (hit != 2'b00);

    // Byte enables inside one line
    always_comb begin
        case (pipe_type)
            ST_W:    store_be = 16'h000f << {pipe_addr[3:2], 2'b00};
            ST_H:    store_be = pipe_addr[0] ? 16'h0000 : 16'h0003 << pipe_addr[OFFSET_W-1:0];
            ST_B:    store_be = 16'h0001 << pipe_addr[OFFSET_W-1:0];
            default: store_be = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    //////////////////////////////
    // Next state and outputs
    always_comb begin
        state_next      = state;
        req_ready       = 1'b0;
        resp_valid      = 1'b0;
        mem_we          = '0;
        tag_we          = '0;
        lru_update      = 1'b0;
        miss_lru_update = 1'b0;
        miss_way        = way_sel;
        refill_sel      = 1'b0;
        d_arvalid       = 1'b0;
        d_araddr        = '0;
        d_rready        = 1'b0;
        wb_start        = 1'b0;
        wb_clear        = 1'b0;
        case (state)
            IDLE: begin
                req_ready = 1'b1;
                if (req_fire) begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                if (is_hit) begin
                    req_ready  = 1'b1;
                    resp_valid = 1'b1;
                    lru_update = 1'b1;
                    if (pipe_we) begin
                        mem_we = hit[1] ? {store_be, 16'h0000} : {16'h0000, store_be};
                        tag_we = hit;
                    end
                    state_next = req_fire ? LOOKUP : IDLE;
                end else if (pipe_valid) begin
                    // Victim leaves while the line is fetched
                    wb_start   = 1'b1;
                    state_next = MISS_A;
                end else begin
                    state_next = IDLE;
                end
            end
            MISS_A: begin
                d_arvalid = 1'b1;
                d_araddr  = {pipe_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
                if (d_arready) begin
                    state_next = MISS;
                end
            end
            MISS: begin
                d_rready = 1'b1;
                if (d_rvalid && d_rlast) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                mem_we          = way_sel ? 32'hffff_0000 : 32'h0000_ffff;
                tag_we          = way_sel ? 2'b10 : 2'b01;
                refill_sel      = 1'b1;
                miss_lru_update = 1'b1;
                state_next      = WAIT_WRITE;
            end
            WAIT_WRITE: begin
                if (write_finish) begin
                    wb_clear   = 1'b1;
                    state_next = LOOKUP;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // Replayed request finds the refilled line
    assert property (@(posedge clk) disable iff (!rstn)
        (state == WAIT_WRITE && write_finish) |=> is_hit);

    assert property (@(posedge clk) disable iff (!rstn)
        (d_arvalid && !d_arready) |=> (d_arvalid && $stable(d_araddr)));

endmodule

//--- hw/dcache_pkg.sv
package dcache_pkg;

    // Geometry
    localparam int ADDR_W         = 32;
    localparam int SET_NUM        = 16;
    localparam int INDEX_W        = 4;
    localparam int OFFSET_W       = 4;
    localparam int TAG_W          = 24;
    localparam int LINE_BYTES     = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int WAY_NUM        = 2;

    // Core access opcodes
    typedef enum logic [2:0] {
        LD_W  = 3'b000,
        ST_W  = 3'b001,
        LD_B  = 3'b010,
        LD_H  = 3'b011,
        LD_BU = 3'b100,
        LD_HU = 3'b101,
        ST_B  = 3'b110,
        ST_H  = 3'b111
    } mem_type_e;

    typedef enum logic [2:0] {
        IDLE       = 3'h0,
        LOOKUP     = 3'h1,
        MISS       = 3'h2,
        REFILL     = 3'h3,
        WAIT_WRITE = 3'h4,
        MISS_A     = 3'h5
    } cache_state_e;

endpackage

//--- hw/dcache_tagv_array.sv
`timescale 1ns/1ps

module dcache_tagv_array (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [dcache_pkg::INDEX_W-1:0] index,
    input  logic [dcache_pkg::TAG_W-1:0]   lookup_tag,
    input  logic [1:0]                     tag_we,
    input  logic                           set_dirty,
    input  logic                           way_sel,
    output logic [1:0]                     hit,
    output logic                           victim_dirty,
    output logic [dcache_pkg::TAG_W-1:0]   victim_tag
);
    import dcache_pkg::*;

    logic [TAG_W-1:0]   tag_mem [WAY_NUM][SET_NUM];
    logic [SET_NUM-1:0] valid [WAY_NUM];
    logic [SET_NUM-1:0] dirty [WAY_NUM];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                valid[w] <= '0;
                dirty[w] <= '0;
            end
        end else begin
            for (int w = 0; w < WAY_NUM; w++) begin
                if (tag_we[w] && set_dirty) begin
                    dirty[w][index] <= 1'b1;
                end else if (tag_we[w]) begin
                    // Refilled line starts clean
                    valid[w][index] <= 1'b1;
                    dirty[w][index] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAY_NUM; w++) begin
            if (tag_we[w] && !set_dirty) begin
                tag_mem[w][index] <= lookup_tag;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < WAY_NUM; w++) begin
            hit[w] = valid[w][index] && (tag_mem[w][index] == lookup_tag);
        end
    end

    assign victim_tag   = tag_mem[way_sel][index];
    assign victim_dirty = valid[way_sel][index] && dirty[way_sel][index];

    // A line lives in one way only
    assert property (@(posedge clk) disable iff (!rstn) hit != 2'b11);

endmodule

//--- hw/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          req_valid,
    input  logic                          req_we,
    input  dcache_pkg::mem_type_e         req_type,
    input  logic [dcache_pkg::ADDR_W-1:0] req_addr,
    input  logic [31:0]                   req_wdata,
    output logic                          req_ready,
    output logic                          resp_valid,
    output logic [31:0]                   resp_rdata,
    output logic                          d_arvalid,
    output logic [dcache_pkg::ADDR_W-1:0] d_araddr,
    input  logic                          d_arready,
    input  logic                          d_rvalid,
    input  logic [31:0]                   d_rdata,
    input  logic                          d_rlast,
    output logic                          d_rready,
    output logic                          d_awvalid,
    output logic [dcache_pkg::ADDR_W-1:0] d_awaddr,
    input  logic                          d_awready,
    output logic                          d_wvalid,
    output logic [31:0]                   d_wdata,
    output logic                          d_wlast,
    input  logic                          d_wready,
    input  logic                          d_bvalid
);
    import dcache_pkg::*;

    logic                    req_fire;
    logic                    pipe_valid;
    logic                    pipe_we;
    mem_type_e               pipe_type;
    logic [ADDR_W-1:0]       pipe_addr;
    logic [31:0]             pipe_wdata;
    logic [INDEX_W-1:0]      index;
    logic [TAG_W-1:0]        lookup_tag;
    logic [31:0]             store_word;
    logic [LINE_BYTES*8-1:0] store_data;
    logic [LINE_BYTES*8-1:0] hit_line;
    logic [LINE_BYTES*8-1:0] victim_line;
    logic [31:0]             load_word;
    logic [15:0]             load_half;
    logic [7:0]              load_byte;
    logic [31:0]             mem_we;
    logic [1:0]              tag_we;
    logic [1:0]              hit;
    logic                    set_dirty;
    logic                    way_sel;
    logic                    lru_update;
    logic                    miss_lru_update;
    logic                    miss_way;
    logic                    refill_sel;
    logic                    wb_start;
    logic                    wb_clear;
    logic                    write_finish;
    logic                    victim_dirty;
    logic [TAG_W-1:0]        victim_tag;

    assign req_fire = req_valid && req_ready;

    //////////////////////////////
    // Request register
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pipe_valid <= 1'b0;
        end else if (req_fire) begin
            pipe_valid <= 1'b1;
        end else if (resp_valid) begin
            pipe_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            pipe_we    <= req_we;
            pipe_type  <= req_type;
            pipe_addr  <= req_addr;
            pipe_wdata <= req_wdata;
        end
    end

    assign index      = pipe_addr[OFFSET_W +: INDEX_W];
    assign lookup_tag = pipe_addr[ADDR_W-1 -: TAG_W];
    // Tag writes outside a refill only mark the line dirty
    assign set_dirty  = ~refill_sel;

    // Store data repeated over every lane
    always_comb begin
        case (pipe_type)
            ST_B:    store_word = {4{pipe_wdata[7:0]}};
            ST_H:    store_word = {2{pipe_wdata[15:0]}};
            default: store_word = pipe_wdata;
        endcase
    end

    assign store_data = {WORDS_PER_LINE{store_word}};

    //////////////////////////////
    // Load extraction
    assign load_word = hit_line[pipe_addr[3:2]*32 +: 32];
    assign load_half = load_word[pipe_addr[1]*16 +: 16];
    assign load_byte = load_word[pipe_addr[1:0]*8 +: 8];

    always_comb begin
        case (pipe_type)
            LD_B:    resp_rdata = {{24{load_byte[7]}}, load_byte};
            LD_BU:   resp_rdata = {24'h0, load_byte};
            LD_H:    resp_rdata = {{16{load_half[15]}}, load_half};
            LD_HU:   resp_rdata = {16'h0, load_half};
            default: resp_rdata = load_word;
        endcase
    end

    dcache_main_fsm u_main_fsm (.*);

    dcache_tagv_array u_tagv (.*);

    dcache_data_array u_data (.*);

    dcache_lru u_lru (.*);

    dcache_writeback_fsm u_wb (.*);

endmodule

//--- hw/dcache_writeback_fsm.sv
`timescale 1ns/1ps

module dcache_writeback_fsm (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                wb_start,
    input  logic                                wb_clear,
    input  logic                                victim_dirty,
    input  logic [dcache_pkg::TAG_W-1:0]        victim_tag,
    input  logic [dcache_pkg::INDEX_W-1:0]      index,
    input  logic [dcache_pkg::LINE_BYTES*8-1:0] victim_line,
    output logic                                d_awvalid,
    output logic [dcache_pkg::ADDR_W-1:0]       d_awaddr,
    input  logic                                d_awready,
    output logic                                d_wvalid,
    output logic [31:0]                         d_wdata,
    output logic                                d_wlast,
    input  logic                                d_wready,
    input  logic                                d_bvalid,
    output logic                                write_finish
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        WB_IDLE,
        WB_CHECK,
        WB_ADDR,
        WB_DATA,
        WB_RESP,
        WB_DONE
    } wb_state_e;

    wb_state_e               state;
    wb_state_e               state_next;
    logic                    dirty_q;
    logic [1:0]              beat_cnt;
    logic [LINE_BYTES*8-1:0] line_q;
    logic [ADDR_W-1:0]       addr_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= WB_IDLE;
            dirty_q  <= 1'b0;
            beat_cnt <= '0;
        end else begin
            state <= state_next;
            if (wb_start) begin
                dirty_q  <= victim_dirty;
                beat_cnt <= '0;
            end else if (d_wvalid && d_wready) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Snapshot before the refill overwrites the way
    always_ff @(posedge clk) begin
        if (wb_start) begin
            line_q <= victim_line;
            addr_q <= {victim_tag, index, {OFFSET_W{1'b0}}};
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            WB_IDLE:  state_next = wb_start ? WB_CHECK : WB_IDLE;
            WB_CHECK: state_next = dirty_q ? WB_ADDR : WB_DONE;
            WB_ADDR:  state_next = d_awready ? WB_DATA : WB_ADDR;
            WB_DATA:  state_next = (d_wready && d_wlast) ? WB_RESP : WB_DATA;
            WB_RESP:  state_next = d_bvalid ? WB_DONE : WB_RESP;
            WB_DONE:  state_next = wb_clear ? WB_IDLE : WB_DONE;
            default:  state_next = WB_IDLE;
        endcase
    end

    assign d_awvalid    = (state == WB_ADDR);
    assign d_awaddr     = addr_q;
    assign d_wvalid     = (state == WB_DATA);
    assign d_wdata      = line_q[beat_cnt*32 +: 32];
    assign d_wlast      = d_wvalid && (beat_cnt == 2'(WORDS_PER_LINE - 1));
    assign write_finish = (state == WB_DONE);

endmodule

//--- run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f flist.f && \
    ./obj_dir/Vdcache_tb | tee /dev/stderr | grep -q "TESTBENCH PASSED" && \
    echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

//--- verif/dcache_clkgen.sv
`timescale 1ns/1ps

module dcache_clkgen (
    output logic clk,
    output logic rstn
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

endmodule

//--- verif/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    typedef struct {
        logic        we;
        mem_type_e   kind;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        hit_exp;
        logic        wb_exp;
        logic [31:0] wb_addr;
    } access_t;

    logic        clk;
    logic        rstn;
    logic        req_valid;
    logic        req_we;
    mem_type_e   req_type;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic        req_ready;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic        d_arvalid;
    logic [31:0] d_araddr;
    logic        d_arready;
    logic        d_rvalid;
    logic [31:0] d_rdata;
    logic        d_rlast;
    logic        d_rready;
    logic        d_awvalid;
    logic [31:0] d_awaddr;
    logic        d_awready;
    logic        d_wvalid;
    logic [31:0] d_wdata;
    logic        d_wlast;
    logic        d_wready;
    logic        d_bvalid;

    access_t     accesses[$];
    logic [31:0] mem_words [1024];
    logic [7:0]  shadow [4096];
    logic [31:0] wb_addrs[$];
    logic [31:0] wb_words[$];
    int          wb_count = 0;
    int          cycle = 0;
    int          cycle_limit = 0;
    logic [31:0] lfsr_state = 32'he64d_880d;

    dcache_clkgen clkgen0 (.clk(clk), .rstn(rstn));

    dcache_top dut0 (.*);

    task automatic fail_now(string msg);
        $display("%s at %0t", msg, $time);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Galois LFSR, one step per bit
    function automatic int take_bits(int n);
        int   value;
        logic lsb;
        value = 0;
        for (int k = 0; k < n; k++) begin
            lsb        = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (lsb ? 32'h8020_0003 : 32'h0);
            value      = (value << 1) | int'(lsb);
        end
        return value;
    endfunction

    task automatic wait_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    //////////////////////////////
    // Shadow memory
    function automatic logic [31:0] shadow_word(logic [31:0] addr);
        return {shadow[{addr[11:2], 2'd3}], shadow[{addr[11:2], 2'd2}],
                shadow[{addr[11:2], 2'd1}], shadow[{addr[11:2], 2'd0}]};
    endfunction

    function automatic logic [31:0] expected_load(mem_type_e kind, logic [31:0] addr);
        logic [7:0]  b;
        logic [15:0] h;
        b = shadow[addr[11:0]];
        h = {shadow[{addr[11:1], 1'b1}], shadow[{addr[11:1], 1'b0}]};
        case (kind)
            LD_B:    return {{24{b[7]}}, b};
            LD_BU:   return {24'h0, b};
            LD_H:    return {{16{h[15]}}, h};
            LD_HU:   return {16'h0, h};
            default: return shadow_word(addr);
        endcase
    endfunction

    task automatic apply_store(mem_type_e kind, logic [31:0] addr, logic [31:0] data);
        case (kind)
            ST_W: begin
                for (int k = 0; k < 4; k++) begin
                    shadow[{addr[11:2], 2'(k)}] = data[k*8 +: 8];
                end
            end
            // Odd half address leaves memory unchanged
            ST_H: begin
                if (!addr[0]) begin
                    shadow[addr[11:0]]         = data[7:0];
                    shadow[addr[11:0] + 12'd1] = data[15:8];
                end
            end
            ST_B:    shadow[addr[11:0]] = data[7:0];
            default: ;
        endcase
    endtask

    //////////////////////////////
    // Access table
    task automatic add_access(logic we, mem_type_e kind, logic [31:0] addr, logic [31:0] wdata,
                              logic hit_exp, logic wb_exp, logic [31:0] wb_addr);
        access_t e;
        e.we      = we;
        e.kind    = kind;
        e.addr    = addr;
        e.wdata   = wdata;
        e.hit_exp = hit_exp;
        e.wb_exp  = wb_exp;
        e.wb_addr = wb_addr;
        accesses.push_back(e);
    endtask

    task automatic store_then_loads(mem_type_e kind, logic [31:0] addr, logic [31:0] data);
        logic [31:0] half_addr;
        logic [31:0] word_addr;
        half_addr = {addr[31:1], 1'b0};
        word_addr = {addr[31:2], 2'b00};
        add_access(1'b1, kind, addr, data, 1'b1, 1'b0, 32'h0);
        add_access(1'b0, LD_W, word_addr, 32'h0, 1'b1, 1'b0, 32'h0);
        add_access(1'b0, LD_H, half_addr, 32'h0, 1'b1, 1'b0, 32'h0);
        add_access(1'b0, LD_HU, half_addr, 32'h0, 1'b1, 1'b0, 32'h0);
        add_access(1'b0, LD_B, addr, 32'h0, 1'b1, 1'b0, 32'h0);
        add_access(1'b0, LD_BU, addr, 32'h0, 1'b1, 1'b0, 32'h0);
    endtask

    task automatic build_table();
        // Cold miss, then a hit in the same line
        add_access(1'b0, LD_W, 32'h010, 32'h0, 1'b0, 1'b0, 32'h0);
        add_access(1'b0, LD_W, 32'h014, 32'h0, 1'b1, 1'b0, 32'h0);
        store_then_loads(ST_W, 32'h018, 32'h8bad_f00d);
        store_then_loads(ST_B, 32'h01c, 32'hdead_be91);
        store_then_loads(ST_B, 32'h01d, 32'h1234_567e);
        store_then_loads(ST_B, 32'h01e, 32'h0000_00c3);
        store_then_loads(ST_B, 32'h01f, 32'hffff_ff25);
        store_then_loads(ST_H, 32'h014, 32'haaaa_8001);
        store_then_loads(ST_H, 32'h016, 32'h5555_7ffe);
        // Set 1 with lines 0x010, 0x110 and 0x210
        add_access(1'b0, LD_W, 32'h110, 32'h0, 1'b0, 1'b0, 32'h0);
        add_access(1'b0, LD_HU, 32'h016, 32'h0, 1'b1, 1'b0, 32'h0);
        add_access(1'b0, LD_W, 32'h210, 32'h0, 1'b0, 1'b0, 32'h0);
        add_access(1'b0, LD_B, 32'h01c, 32'h0, 1'b1, 1'b0, 32'h0);
        add_access(1'b0, LD_W, 32'h110, 32'h0, 1'b0, 1'b0, 32'h0);
        add_access(1'b0, LD_W, 32'h21c, 32'h0, 1'b0, 1'b1, 32'h010);
        add_access(1'b0, LD_W, 32'h018, 32'h0, 1'b0, 1'b0, 32'h0);
        add_access(1'b0, LD_H, 32'h014, 32'h0, 1'b1, 1'b0, 32'h0);
        // Set 2, line dirtied by a store miss
        add_access(1'b1, ST_B, 32'h224, 32'h0000_0080, 1'b0, 1'b0, 32'h0);
        add_access(1'b1, ST_H, 32'h226, 32'h0000_9abc, 1'b1, 1'b0, 32'h0);
        add_access(1'b0, LD_W, 32'h224, 32'h0, 1'b1, 1'b0, 32'h0);
        add_access(1'b0, LD_W, 32'h124, 32'h0, 1'b0, 1'b0, 32'h0);
        add_access(1'b0, LD_W, 32'h324, 32'h0, 1'b0, 1'b1, 32'h220);
        add_access(1'b0, LD_BU, 32'h224, 32'h0, 1'b0, 1'b0, 32'h0);
        add_access(1'b0, LD_H, 32'h226, 32'h0, 1'b1, 1'b0, 32'h0);
        add_access(1'b0, LD_B, 32'h224, 32'h0, 1'b1, 1'b0, 32'h0);
    endtask

    task automatic finish_response(access_t e, logic [31:0] exp_rdata, int acc_cycle,
                                   int wb_before);
        int base;
        check_value("resp_valid one cycle", 32'(cycle - acc_cycle == 1), 32'(e.hit_exp));
        if (!e.we) begin
            check_value("resp_rdata", resp_rdata, exp_rdata);
        end
        check_value("write bursts", 32'(wb_count - wb_before), 32'(e.wb_exp));
        if (e.wb_exp) begin
            check_value("d_awaddr", wb_addrs[wb_addrs.size() - 1], e.wb_addr);
            base = wb_words.size() - WORDS_PER_LINE;
            for (int k = 0; k < WORDS_PER_LINE; k++) begin
                check_value("d_wdata", wb_words[base + k], shadow_word(e.wb_addr + 32'(4 * k)));
            end
        end
    endtask

    //////////////////////////////
    // Memory model, read side
    initial begin
        logic [31:0] addr;
        wait (rstn === 1'b1);
        forever begin
            do begin
                @(negedge clk);
            end while (!d_arvalid);
            addr = d_araddr;
            check_value("d_araddr[3:0]", 32'(addr[3:0]), 32'h0);
            if (addr[31:12] != '0) begin
                fail_now("Read burst address lies outside the memory model");
            end
            wait_cycles(1);
            wait_cycles(take_bits(2));
            d_arready = 1'b1;
            wait_cycles(1);
            d_arready = 1'b0;
            for (int b = 0; b < WORDS_PER_LINE; b++) begin
                d_rvalid = 1'b1;
                d_rdata  = mem_words[int'(addr[11:2]) + b];
                d_rlast  = (b == WORDS_PER_LINE - 1);
                @(negedge clk);
                check_value("d_rready", 32'(d_rready), 32'h1);
                wait_cycles(1);
            end
            d_rvalid = 1'b0;
            d_rlast  = 1'b0;
        end
    end

    //////////////////////////////
    // Memory model, write side
    initial begin
        logic [31:0] addr;
        wait (rstn === 1'b1);
        forever begin
            do begin
                @(negedge clk);
            end while (!d_awvalid);
            addr = d_awaddr;
            check_value("d_awaddr[3:0]", 32'(addr[3:0]), 32'h0);
            if (addr[31:12] != '0) begin
                fail_now("Write burst address lies outside the memory model");
            end
            wait_cycles(1);
            wait_cycles(take_bits(2));
            d_awready = 1'b1;
            wait_cycles(1);
            d_awready = 1'b0;
            for (int b = 0; b < WORDS_PER_LINE; b++) begin
                wait_cycles(take_bits(2));
                d_wready = 1'b1;
                @(negedge clk);
                check_value("d_wvalid", 32'(d_wvalid), 32'h1);
                check_value("d_wlast", 32'(d_wlast), 32'(b == WORDS_PER_LINE - 1));
                mem_words[int'(addr[11:2]) + b] = d_wdata;
                wb_words.push_back(d_wdata);
                wait_cycles(1);
                d_wready = 1'b0;
            end
            // No fifth beat
            d_bvalid = 1'b1;
            @(negedge clk);
            check_value("d_wvalid", 32'(d_wvalid), 32'h0);
            wait_cycles(1);
            d_bvalid = 1'b0;
            wb_addrs.push_back(addr);
            wb_count++;
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle_limit != 0 && cycle > cycle_limit) begin
            fail_now("Timeout: the access table did not complete within the cycle limit");
        end
    end

    //////////////////////////////
    // Table loop
    initial begin
        access_t     cur;
        access_t     prev;
        logic [31:0] cur_exp;
        logic [31:0] prev_exp;
        int          waits;
        int          acc_cycle;
        int          prev_wb;
        logic        pending;
        req_valid = 1'b0;
        req_we    = 1'b0;
        req_type  = LD_W;
        req_addr  = '0;
        req_wdata = '0;
        d_arready = 1'b0;
        d_rvalid  = 1'b0;
        d_rdata   = '0;
        d_rlast   = 1'b0;
        d_awready = 1'b0;
        d_wready  = 1'b0;
        d_bvalid  = 1'b0;
        pending   = 1'b0;
        acc_cycle = 0;
        prev_wb   = 0;
        for (int a = 0; a < 1024; a++) begin
            mem_words[a] = 32'(a) ^ 32'ha5a5_0000;
            for (int k = 0; k < 4; k++) begin
                shadow[a * 4 + k] = mem_words[a][k*8 +: 8];
            end
        end
        build_table();
        cycle_limit = accesses.size() * 60;
        wait (rstn === 1'b1);
        wait_cycles(1);
        for (int i = 0; i < accesses.size(); i++) begin
            cur       = accesses[i];
            cur_exp   = expected_load(cur.kind, cur.addr);
            req_valid = 1'b1;
            req_we    = cur.we;
            req_type  = cur.kind;
            req_addr  = cur.addr;
            req_wdata = cur.wdata;
            waits     = -1;
            do begin
                @(negedge clk);
                waits++;
                if (resp_valid) begin
                    if (!pending) begin
                        fail_now("Response arrived with no request outstanding");
                    end
                    finish_response(prev, prev_exp, acc_cycle, prev_wb);
                    pending = 1'b0;
                end
            end while (!req_ready);
            if (pending) begin
                fail_now("Request accepted while the previous one was still outstanding");
            end
            // Hit streaming keeps req_ready high
            if (i > 0 && prev.hit_exp) begin
                check_value("req_ready stall cycles", 32'(waits), 32'h0);
            end
            acc_cycle = cycle;
            prev_wb   = wb_count;
            wait_cycles(1);
            if (cur.we) begin
                apply_store(cur.kind, cur.addr, cur.wdata);
            end
            prev     = cur;
            prev_exp = cur_exp;
            pending  = 1'b1;
        end
        req_valid = 1'b0;
        while (pending) begin
            @(negedge clk);
            if (resp_valid) begin
                finish_response(prev, prev_exp, acc_cycle, prev_wb);
                pending = 1'b0;
            end
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
